// ==== buf_cfg_pkg.sv ====
// Result buffer configuration
// Word and address widths, slot layout and staging FIFO size

package buf_cfg_pkg;

  // Result word and RAM geometry
  localparam int DATA_W    = 16;
  localparam int ADDR_W    = 13;
  localparam int RAM_DEPTH = 8192;

  // Five slots, 1550 words apart
  localparam int SLOT_COUNT  = 5;
  localparam int SLOT_STRIDE = 1550;

  // Slot index and packet length widths
  localparam int SLOT_W = 3;
  localparam int LEN_W  = 11;

  // Writer staging FIFO, power of two
  localparam int FIFO_DEPTH = 4;

endpackage

// ==== buf_ctrl_pkg.sv ====
// Result buffer control encodings
// Slot rotation states, arbiter owner and writer states

package buf_ctrl_pkg;

  // One ADDR and one IDLE state per slot
  typedef enum logic [3:0] {
    ADDR0, IDLE0,
    ADDR1, IDLE1,
    ADDR2, IDLE2,
    ADDR3, IDLE3,
    ADDR4, IDLE4
  } slot_state_t;

  // Owner of the RAM port
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_WR,
    GRANT_RD
  } grant_t;

  // Result writer
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_REQ,
    WR_NEXT_SLOT
  } wr_state_t;

endpackage

// ==== result_address_fsm.sv ====
// Result slot rotation FSM
// Steps the write base through the five slots, one step per finished packet,
// and pulses slot_strobe when the new base is presented

`timescale 1ns/1ns

module result_address_fsm (
  input  logic                          clk,
  input  logic                          n_rst,
  input  logic                          inc_addr,
  output logic [buf_cfg_pkg::ADDR_W-1:0] base_addr,
  output logic [buf_cfg_pkg::SLOT_W-1:0] slot_idx,
  output logic                          slot_strobe
);

  buf_ctrl_pkg::slot_state_t state_q;
  buf_ctrl_pkg::slot_state_t state_d;
  logic [buf_cfg_pkg::ADDR_W-1:0] base_d;
  logic [buf_cfg_pkg::SLOT_W-1:0] idx_d;
  logic                           strobe_d;

  // IDLE waits for inc_addr, ADDR lasts one cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      buf_ctrl_pkg::ADDR0: state_d = buf_ctrl_pkg::IDLE0;
      buf_ctrl_pkg::IDLE0: if (inc_addr) state_d = buf_ctrl_pkg::ADDR1;
      buf_ctrl_pkg::ADDR1: state_d = buf_ctrl_pkg::IDLE1;
      buf_ctrl_pkg::IDLE1: if (inc_addr) state_d = buf_ctrl_pkg::ADDR2;
      buf_ctrl_pkg::ADDR2: state_d = buf_ctrl_pkg::IDLE2;
      buf_ctrl_pkg::IDLE2: if (inc_addr) state_d = buf_ctrl_pkg::ADDR3;
      buf_ctrl_pkg::ADDR3: state_d = buf_ctrl_pkg::IDLE3;
      buf_ctrl_pkg::IDLE3: if (inc_addr) state_d = buf_ctrl_pkg::ADDR4;
      buf_ctrl_pkg::ADDR4: state_d = buf_ctrl_pkg::IDLE4;
      // Fifth slot wraps back to the first
      buf_ctrl_pkg::IDLE4: if (inc_addr) state_d = buf_ctrl_pkg::ADDR0;
      default:             state_d = buf_ctrl_pkg::IDLE0;
    endcase
  end

  // Base and index of the slot that the current state belongs to
  always_comb begin
    case (state_q)
      buf_ctrl_pkg::ADDR0, buf_ctrl_pkg::IDLE0: begin
        base_d = '0;
        idx_d  = 3'd0;
      end
      buf_ctrl_pkg::ADDR1, buf_ctrl_pkg::IDLE1: begin
        base_d = buf_cfg_pkg::ADDR_W'(1 * buf_cfg_pkg::SLOT_STRIDE);
        idx_d  = 3'd1;
      end
      buf_ctrl_pkg::ADDR2, buf_ctrl_pkg::IDLE2: begin
        base_d = buf_cfg_pkg::ADDR_W'(2 * buf_cfg_pkg::SLOT_STRIDE);
        idx_d  = 3'd2;
      end
      buf_ctrl_pkg::ADDR3, buf_ctrl_pkg::IDLE3: begin
        base_d = buf_cfg_pkg::ADDR_W'(3 * buf_cfg_pkg::SLOT_STRIDE);
        idx_d  = 3'd3;
      end
      buf_ctrl_pkg::ADDR4, buf_ctrl_pkg::IDLE4: begin
        base_d = buf_cfg_pkg::ADDR_W'(4 * buf_cfg_pkg::SLOT_STRIDE);
        idx_d  = 3'd4;
      end
      default: begin
        base_d = '0;
        idx_d  = 3'd0;
      end
    endcase
    strobe_d = state_q inside {buf_ctrl_pkg::ADDR0, buf_ctrl_pkg::ADDR1,
                               buf_ctrl_pkg::ADDR2, buf_ctrl_pkg::ADDR3,
                               buf_ctrl_pkg::ADDR4};
  end

  // Outputs lag the state by a cycle, so strobe and new base appear together
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state_q     <= buf_ctrl_pkg::IDLE0;
      base_addr   <= '0;
      slot_idx    <= '0;
      slot_strobe <= 1'b0;
    end else begin
      state_q     <= state_d;
      base_addr   <= base_d;
      slot_idx    <= idx_d;
      slot_strobe <= strobe_d;
    end
  end

endmodule

// ==== result_writer.sv ====
// Result writer
// Stages engine words in a small FIFO, writes them into the current slot
// and reports slot, length and truncation once per packet

`timescale 1ns/1ns

module result_writer (
  input  logic                           clk,
  input  logic                           n_rst,
  input  logic                           res_valid,
  input  logic [buf_cfg_pkg::DATA_W-1:0] res_data,
  input  logic                           res_last,
  output logic                           res_overflow,
  input  logic [buf_cfg_pkg::ADDR_W-1:0] base_addr,
  input  logic [buf_cfg_pkg::SLOT_W-1:0] slot_idx,
  input  logic                           slot_strobe,
  output logic                           inc_addr,
  output logic                           wr_req,
  input  logic                           gnt_wr,
  output logic [buf_cfg_pkg::ADDR_W-1:0] wr_addr,
  output logic [buf_cfg_pkg::DATA_W-1:0] wr_data,
  output logic                           done_valid,
  output logic [buf_cfg_pkg::SLOT_W-1:0] done_slot,
  output logic [buf_cfg_pkg::LEN_W-1:0]  done_len,
  output logic                           done_trunc
);

  logic [buf_cfg_pkg::DATA_W-1:0] fifo_data [buf_cfg_pkg::FIFO_DEPTH];
  logic                           fifo_last [buf_cfg_pkg::FIFO_DEPTH];
  logic [$clog2(buf_cfg_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(buf_cfg_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(buf_cfg_pkg::FIFO_DEPTH+1)-1:0] count;
  logic fifo_full;
  logic push;
  logic pop;
  logic active;
  logic slot_full;
  logic head_last;
  logic [buf_cfg_pkg::LEN_W-1:0] offset;
  logic                          trunc;
  buf_ctrl_pkg::wr_state_t       state;

  assign fifo_full = count == buf_cfg_pkg::FIFO_DEPTH;
  assign push      = res_valid && !fifo_full;
  assign head_last = fifo_last[rd_ptr];
  assign slot_full = offset == buf_cfg_pkg::LEN_W'(buf_cfg_pkg::SLOT_STRIDE);

  // No pops while the FSM moves to the next slot
  assign active = count != '0 && state != buf_ctrl_pkg::WR_NEXT_SLOT;
  assign wr_req = active && !slot_full;
  // Words past the slot end leave the FIFO without a RAM write
  assign pop    = active && (slot_full || gnt_wr);

  assign wr_addr = base_addr + buf_cfg_pkg::ADDR_W'(offset);
  assign wr_data = fifo_data[rd_ptr];

  // FIFO storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data[wr_ptr] <= res_data;
      fifo_last[wr_ptr] <= res_last;
    end else if (res_valid && res_last && fifo_full) begin
      // Dropped last word still closes the packet on the newest entry
      fifo_last[wr_ptr - 1'b1] <= 1'b1;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      res_overflow <= 1'b0;
    end else begin
      res_overflow <= res_valid && fifo_full;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Packet state, word offset and completion pulses
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state      <= buf_ctrl_pkg::WR_IDLE;
      offset     <= '0;
      trunc      <= 1'b0;
      done_valid <= 1'b0;
      inc_addr   <= 1'b0;
    end else begin
      done_valid <= pop && head_last;
      inc_addr   <= pop && head_last;
      if (state == buf_ctrl_pkg::WR_NEXT_SLOT) begin
        if (slot_strobe) begin
          state  <= buf_ctrl_pkg::WR_IDLE;
          offset <= '0;
          trunc  <= 1'b0;
        end
      end else if (pop) begin
        if (head_last) begin
          state <= buf_ctrl_pkg::WR_NEXT_SLOT;
        end else begin
          state <= buf_ctrl_pkg::WR_REQ;
        end
        if (slot_full) begin
          trunc <= 1'b1;
        end else begin
          offset <= offset + 1'b1;
        end
      end
    end
  end

  // Report fields, loaded with the last word
  always_ff @(posedge clk) begin
    if (pop && head_last) begin
      done_slot  <= slot_idx;
      done_len   <= slot_full ? offset : offset + 1'b1;
      done_trunc <= trunc || slot_full;
    end
  end

endmodule

// ==== host_reader.sv ====
// Host read port
// One word per rd_cmd, read from slot base plus offset through the arbiter

`timescale 1ns/1ns

module host_reader (
  input  logic                           clk,
  input  logic                           n_rst,
  input  logic                           rd_cmd,
  input  logic [buf_cfg_pkg::SLOT_W-1:0] rd_slot,
  input  logic [buf_cfg_pkg::LEN_W-1:0]  rd_offset,
  output logic                           rd_busy,
  output logic                           rd_req,
  input  logic                           gnt_rd,
  output logic [buf_cfg_pkg::ADDR_W-1:0] rd_addr,
  input  logic [buf_cfg_pkg::DATA_W-1:0] ram_rdata,
  output logic                           rd_valid,
  output logic [buf_cfg_pkg::DATA_W-1:0] rd_data
);

  logic accept;
  logic capture;

  // Commands while busy are dropped
  assign accept = rd_cmd && !rd_busy;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      rd_busy  <= 1'b0;
      rd_req   <= 1'b0;
      capture  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= capture;
      capture  <= rd_req && gnt_rd;
      if (accept) begin
        rd_busy <= 1'b1;
        rd_req  <= 1'b1;
      end else if (rd_req && gnt_rd) begin
        rd_req <= 1'b0;
      end else if (capture) begin
        rd_busy <= 1'b0;
      end
    end
  end

  // Slot base from index times stride
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_addr <= buf_cfg_pkg::ADDR_W'(rd_slot * buf_cfg_pkg::SLOT_STRIDE)
               + buf_cfg_pkg::ADDR_W'(rd_offset);
    end
  end

  // RAM output is valid the cycle after the grant
  always_ff @(posedge clk) begin
    if (capture) begin
      rd_data <= ram_rdata;
    end
  end

endmodule

// ==== mem_arbiter.sv ====
// RAM port arbiter
// Round-robin between writer and reader, grant in the same cycle as the access

`timescale 1ns/1ns

module mem_arbiter (
  input  logic                           clk,
  input  logic                           n_rst,
  input  logic                           wr_req,
  input  logic [buf_cfg_pkg::ADDR_W-1:0] wr_addr,
  input  logic [buf_cfg_pkg::DATA_W-1:0] wr_data,
  input  logic                           rd_req,
  input  logic [buf_cfg_pkg::ADDR_W-1:0] rd_addr,
  output logic                           gnt_wr,
  output logic                           gnt_rd,
  output logic                           ram_en,
  output logic                           ram_we,
  output logic [buf_cfg_pkg::ADDR_W-1:0] ram_addr,
  output logic [buf_cfg_pkg::DATA_W-1:0] ram_wdata
);

  buf_ctrl_pkg::grant_t last_q;
  buf_ctrl_pkg::grant_t owner;

  // On a tie the side not served last time wins
  always_comb begin
    if (wr_req && rd_req) begin
      owner = (last_q == buf_ctrl_pkg::GRANT_WR) ? buf_ctrl_pkg::GRANT_RD
                                                  : buf_ctrl_pkg::GRANT_WR;
    end else if (wr_req) begin
      owner = buf_ctrl_pkg::GRANT_WR;
    end else if (rd_req) begin
      owner = buf_ctrl_pkg::GRANT_RD;
    end else begin
      owner = buf_ctrl_pkg::GRANT_NONE;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      last_q <= buf_ctrl_pkg::GRANT_NONE;
    end else if (owner != buf_ctrl_pkg::GRANT_NONE) begin
      last_q <= owner;
    end
  end

  assign gnt_wr    = owner == buf_ctrl_pkg::GRANT_WR;
  assign gnt_rd    = owner == buf_ctrl_pkg::GRANT_RD;
  assign ram_en    = gnt_wr || gnt_rd;
  assign ram_we    = gnt_wr;
  assign ram_addr  = gnt_wr ? wr_addr : rd_addr;
  assign ram_wdata = wr_data;

endmodule

// ==== buffer_ram.sv ====
// Shared result buffer RAM
// Single port, synchronous write, read data one cycle after a read access

`timescale 1ns/1ns

module buffer_ram (
  input  logic                           clk,
  input  logic                           ram_en,
  input  logic                           ram_we,
  input  logic [buf_cfg_pkg::ADDR_W-1:0] ram_addr,
  input  logic [buf_cfg_pkg::DATA_W-1:0] ram_wdata,
  output logic [buf_cfg_pkg::DATA_W-1:0] ram_rdata
);

  logic [buf_cfg_pkg::DATA_W-1:0] mem [buf_cfg_pkg::RAM_DEPTH];

  // Read data holds through writes and idle cycles
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end else begin
        ram_rdata <= mem[ram_addr];
      end
    end
  end

endmodule

// ==== result_buffer_top.sv ====
// Result buffer top level
// Slot FSM, result writer and host reader sharing one RAM through the arbiter

`timescale 1ns/1ns

module result_buffer_top (
  input  logic                           clk,
  input  logic                           n_rst,
  input  logic                           res_valid,
  input  logic [buf_cfg_pkg::DATA_W-1:0] res_data,
  input  logic                           res_last,
  output logic                           res_overflow,
  output logic                           done_valid,
  output logic [buf_cfg_pkg::SLOT_W-1:0] done_slot,
  output logic [buf_cfg_pkg::LEN_W-1:0]  done_len,
  output logic                           done_trunc,
  input  logic                           rd_cmd,
  input  logic [buf_cfg_pkg::SLOT_W-1:0] rd_slot,
  input  logic [buf_cfg_pkg::LEN_W-1:0]  rd_offset,
  output logic                           rd_busy,
  output logic                           rd_valid,
  output logic [buf_cfg_pkg::DATA_W-1:0] rd_data
);

  logic [buf_cfg_pkg::ADDR_W-1:0] base_addr;
  logic [buf_cfg_pkg::SLOT_W-1:0] slot_idx;
  logic                           slot_strobe;
  logic                           inc_addr;
  logic                           wr_req;
  logic                           gnt_wr;
  logic [buf_cfg_pkg::ADDR_W-1:0] wr_addr;
  logic [buf_cfg_pkg::DATA_W-1:0] wr_data;
  logic                           rd_req;
  logic                           gnt_rd;
  logic [buf_cfg_pkg::ADDR_W-1:0] rd_addr;
  logic                           ram_en;
  logic                           ram_we;
  logic [buf_cfg_pkg::ADDR_W-1:0] ram_addr;
  logic [buf_cfg_pkg::DATA_W-1:0] ram_wdata;
  logic [buf_cfg_pkg::DATA_W-1:0] ram_rdata;

  result_address_fsm fsm_i (
    .clk, .n_rst, .inc_addr, .base_addr, .slot_idx, .slot_strobe
  );

  result_writer writer_i (
    .clk, .n_rst, .res_valid, .res_data, .res_last, .res_overflow,
    .base_addr, .slot_idx, .slot_strobe, .inc_addr,
    .wr_req, .gnt_wr, .wr_addr, .wr_data,
    .done_valid, .done_slot, .done_len, .done_trunc
  );

  host_reader reader_i (
    .clk, .n_rst, .rd_cmd, .rd_slot, .rd_offset, .rd_busy,
    .rd_req, .gnt_rd, .rd_addr, .ram_rdata, .rd_valid, .rd_data
  );

  mem_arbiter arb_i (
    .clk, .n_rst, .wr_req, .wr_addr, .wr_data, .rd_req, .rd_addr,
    .gnt_wr, .gnt_rd, .ram_en, .ram_we, .ram_addr, .ram_wdata
  );

  buffer_ram ram_i (
    .clk, .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

endmodule

// ==== tb_result_buffer.sv ====
// Result buffer testbench
// Random packets through all slots, host read-back, contention and truncation,
// checked against a slot scoreboard

`timescale 1ns/1ns

module tb_result_buffer;

  logic                           clk;
  logic                           n_rst;
  logic                           res_valid;
  logic [buf_cfg_pkg::DATA_W-1:0] res_data;
  logic                           res_last;
  logic                           res_overflow;
  logic                           done_valid;
  logic [buf_cfg_pkg::SLOT_W-1:0] done_slot;
  logic [buf_cfg_pkg::LEN_W-1:0]  done_len;
  logic                           done_trunc;
  logic                           rd_cmd;
  logic [buf_cfg_pkg::SLOT_W-1:0] rd_slot;
  logic [buf_cfg_pkg::LEN_W-1:0]  rd_offset;
  logic                           rd_busy;
  logic                           rd_valid;
  logic [buf_cfg_pkg::DATA_W-1:0] rd_data;

  int          mismatch_count;
  int          timeout_count;
  logic [31:0] lfsr_state;
  // Scoreboard of expected words per slot in RAM layout
  logic [buf_cfg_pkg::DATA_W-1:0] exp_mem [buf_cfg_pkg::SLOT_COUNT * buf_cfg_pkg::SLOT_STRIDE];
  int          exp_len [buf_cfg_pkg::SLOT_COUNT];
  int          next_slot;
  int          last_slot;
  int          kept;

  result_buffer_top dut_i (.*);

  always #20 clk = ~clk;

  task automatic flag_error(input string msg);
    mismatch_count++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  assert property (@(posedge clk) disable iff (!n_rst) rd_valid |-> $past(rd_busy))
    else flag_error("rd_valid without a pending read");
  assert property (@(posedge clk) disable iff (!n_rst) rd_valid |=> !rd_valid)
    else flag_error("rd_valid longer than one cycle");
  assert property (@(posedge clk) disable iff (!n_rst) done_valid |=> !done_valid)
    else flag_error("done_valid longer than one cycle");

  // Dropped words show up as res_overflow one cycle later
  task automatic send_packet(input int len, input bit spaced);
    int base;
    int gap;
    base = next_slot * buf_cfg_pkg::SLOT_STRIDE;
    kept = 0;
    for (int i = 0; i < len; i++) begin
      res_valid = 1'b1;
      res_data  = buf_cfg_pkg::DATA_W'(take_bits(16));
      res_last  = (i == len - 1);
      @(negedge clk);
      if (!res_overflow) begin
        if (kept < buf_cfg_pkg::SLOT_STRIDE) exp_mem[base + kept] = res_data;
        kept++;
      end
      if (spaced && i < len - 1) begin
        res_valid = 1'b0;
        gap = 1 + int'(take_bits(2));
        repeat (gap) @(negedge clk);
      end
    end
    res_valid = 1'b0;
    res_last  = 1'b0;
  endtask

  task automatic check_done();
    int cycles;
    int exp_words;
    cycles = 0;
    exp_words = (kept > buf_cfg_pkg::SLOT_STRIDE) ? buf_cfg_pkg::SLOT_STRIDE : kept;
    while (!done_valid && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!done_valid) begin
      timeout_count++;
      $display("timeout: no done_valid for the packet of slot %0d", next_slot);
    end else begin
      assert (done_slot == buf_cfg_pkg::SLOT_W'(next_slot))
        else flag_error($sformatf("done_slot %0d, expected %0d", done_slot, next_slot));
      assert (done_len == buf_cfg_pkg::LEN_W'(exp_words))
        else flag_error($sformatf("done_len %0d, expected %0d", done_len, exp_words));
      assert (done_trunc == (kept > buf_cfg_pkg::SLOT_STRIDE))
        else flag_error($sformatf("done_trunc %0b for %0d words", done_trunc, kept));
    end
    exp_len[next_slot] = exp_words;
    last_slot = next_slot;
    next_slot = (next_slot + 1) % buf_cfg_pkg::SLOT_COUNT;
    @(negedge clk);
  endtask

  // Second command one cycle later must be ignored
  task automatic read_word(input int slot, input int offset);
    int                             cycles;
    logic [buf_cfg_pkg::DATA_W-1:0] expected;
    expected  = exp_mem[slot * buf_cfg_pkg::SLOT_STRIDE + offset];
    rd_cmd    = 1'b1;
    rd_slot   = buf_cfg_pkg::SLOT_W'(slot);
    rd_offset = buf_cfg_pkg::LEN_W'(offset);
    @(negedge clk);
    rd_offset = buf_cfg_pkg::LEN_W'(offset + 1);
    assert (rd_busy) else flag_error("rd_busy low after rd_cmd");
    @(negedge clk);
    rd_cmd = 1'b0;
    cycles = 0;
    while (!rd_valid && cycles < 100) begin
      assert (rd_busy) else flag_error("rd_busy dropped before rd_valid");
      @(negedge clk);
      cycles++;
    end
    if (!rd_valid) begin
      timeout_count++;
      $display("timeout: no rd_valid for slot %0d offset %0d", slot, offset);
    end else begin
      assert (rd_data == expected)
        else flag_error($sformatf("slot %0d offset %0d read %h, expected %h",
                                  slot, offset, rd_data, expected));
      repeat (2) begin
        @(negedge clk);
        assert (!rd_valid) else flag_error("extra rd_valid after an ignored rd_cmd");
      end
    end
  endtask

  initial begin
    int len;
    int old_slot;
    clk            = 1'b0;
    n_rst          = 1'b0;
    res_valid      = 1'b0;
    res_data       = '0;
    res_last       = 1'b0;
    rd_cmd         = 1'b0;
    rd_slot        = '0;
    rd_offset      = '0;
    mismatch_count = 0;
    timeout_count  = 0;
    lfsr_state     = 32'h0d49508a;
    next_slot      = 0;
    last_slot      = 0;
    repeat (5) begin
      if (n_rst == 1'b0 && $time >= 120) n_rst = 1'b1;
      @(negedge clk);
      assert (!(done_valid || rd_valid || rd_busy || res_overflow))
        else flag_error("status output high during or right after reset");
    end

    // Spaced packets rotate through all slots and wrap
    for (int p = 0; p < 7; p++) begin
      len = 1 + int'(take_bits(5));
      send_packet(len, 1'b1);
      assert (kept == len) else flag_error("word dropped with spaced input");
      check_done();
      for (int i = 0; i < len; i++) read_word(last_slot, i);
    end

    // Words every cycle while reads run on the previous slot
    for (int p = 0; p < 2; p++) begin
      len = 24 + int'(take_bits(4));
      old_slot = last_slot;
      fork
        begin
          send_packet(len, 1'b0);
          check_done();
        end
        for (int i = 0; i < 24; i++) read_word(old_slot, i % exp_len[old_slot]);
      join
      for (int i = 0; i < exp_len[last_slot]; i++) read_word(last_slot, i);
    end

    // Oversized packet followed by a normal one in the next slot
    send_packet(1560, 1'b1);
    check_done();
    read_word(last_slot, 0);
    read_word(last_slot, buf_cfg_pkg::SLOT_STRIDE - 1);
    len = 1 + int'(take_bits(5));
    send_packet(len, 1'b1);
    check_done();
    for (int i = 0; i < len; i++) read_word(last_slot, i);

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
buf_cfg_pkg.sv
buf_ctrl_pkg.sv
result_address_fsm.sv
result_writer.sv
host_reader.sv
mem_arbiter.sv
buffer_ram.sv
result_buffer_top.sv
tb_result_buffer.sv

// ==== Makefile ====
# Verilator build and run for the result buffer testbench

VERILATOR  ?= verilator
TOP        ?= tb_result_buffer
RTL_TOP    ?= result_buffer_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
